/* verilog/rvga_pkg.sv */
package rvga_pkg;

  // ****************************************
  // basic types
  // ****************************************

  typedef logic [31:0] rvga_word;
  typedef logic [4:0]  rvga_reg;

  localparam rvga_word RVGA_PC_STEP = 32'd4; // jal link offset.

  // ****************************************
  // opcodes
  // ****************************************

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // alu funct3.
  localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi.
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl and sra.
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ****************************************
  // instruction word
  // ****************************************

  typedef struct packed {
    logic [6:0] funct7;
    rvga_reg    rs2;
    rvga_reg    rs1;
    logic [2:0] funct3;
    rvga_reg    rd;
    logic [6:0] opcode;
  } rvga_r_view;

  typedef struct packed {
    logic [11:0] imm;
    rvga_reg     rs1;
    logic [2:0]  funct3;
    rvga_reg     rd;
    logic [6:0]  opcode;
  } rvga_i_view;

  // B and J immediates are pieced together from the r view.
  typedef union packed {
    rvga_r_view r;
    rvga_i_view i;
  } rvga_instr_u;

endpackage : rvga_pkg

/* verilog/wb_cword_if.sv */
`timescale 1ns/1ps

interface wb_cword_if
  import rvga_pkg::*;
();

  logic     v;
  rvga_word pc;
  rvga_reg  rd;
  logic     rd_w_v;
  logic     br_v;
  logic     jmp_v;
  logic     bru_result; // compare outcome.
  rvga_word result;     // alu result or target.

  modport exe (
    output v, pc, rd, rd_w_v, br_v, jmp_v, bru_result, result
  );

  modport wb (
    input v, pc, rd, rd_w_v, br_v, jmp_v, bru_result, result
  );

endinterface : wb_cword_if

/* verilog/rvga_regfile.sv */
`timescale 1ns/1ps

module rvga_regfile
  import rvga_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  rvga_reg  rs1_i,
  input  rvga_reg  rs2_i,
  output rvga_word rs1_data_o,
  output rvga_word rs2_data_o,
  input  logic     w_v_i,
  input  rvga_reg  rd_i,
  input  rvga_word rd_data_i
);

  rvga_word regs [31:1]; // x0 is not stored.
  logic     w_en;

  assign w_en = w_v_i && (rd_i != '0);

  // write data is forwarded to a read of the same register.
  function automatic rvga_word read_port(input rvga_reg idx);
    rvga_word data;
    if (idx == '0) begin
      data = '0;
    end else if (w_en && (rd_i == idx)) begin
      data = rd_data_i;
    end else begin
      data = regs[idx];
    end
    return data;
  endfunction

  assign rs1_data_o = read_port(rs1_i);
  assign rs2_data_o = read_port(rs2_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (w_en) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule : rvga_regfile

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
  import rvga_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        issue_v_i,
  input  rvga_instr_u instr_i,
  input  rvga_word    pc_i,
  output rvga_reg     rs1_o,
  output rvga_reg     rs2_o,
  input  rvga_word    rs1_data_i,
  input  rvga_word    rs2_data_i,
  wb_cword_if.exe     cword_o
);

  logic     is_op, is_op_imm, is_branch, is_jal;
  logic     alt_v;
  rvga_word i_imm, b_imm, j_imm;
  rvga_word op_b;
  logic [4:0] shamt;
  rvga_word alu_result;
  rvga_word result_n;
  logic     bru_n;
  logic     rd_w_v_n;

  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;

  // ****************************************
  // decode
  // ****************************************

  assign is_op     = (instr_i.r.opcode == OPC_OP);
  assign is_op_imm = (instr_i.r.opcode == OPC_OP_IMM);
  assign is_branch = (instr_i.r.opcode == OPC_BRANCH);
  assign is_jal    = (instr_i.r.opcode == OPC_JAL);

  assign i_imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign b_imm = {{19{instr_i.r.funct7[6]}}, instr_i.r.funct7[6], instr_i.r.rd[0],
                  instr_i.r.funct7[5:0], instr_i.r.rd[4:1], 1'b0};
  assign j_imm = {{11{instr_i.r.funct7[6]}}, instr_i.r.funct7[6], instr_i.r.rs1,
                  instr_i.r.funct3, instr_i.r.rs2[0], instr_i.r.funct7[5:0],
                  instr_i.r.rs2[4:1], 1'b0};

  // sub only for OP, sra for both.
  assign alt_v = instr_i.r.funct7[5] && (is_op || (instr_i.r.funct3 == F3_SR));
  assign op_b  = is_op ? rs2_data_i : i_imm;
  assign shamt = op_b[4:0];

  // ****************************************
  // alu and branch unit
  // ****************************************

  always_comb begin
    case (instr_i.r.funct3)
      F3_ADD:  alu_result = alt_v ? (rs1_data_i - op_b) : (rs1_data_i + op_b);
      F3_SLL:  alu_result = rs1_data_i << shamt;
      F3_SLT:  alu_result = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
      F3_SLTU: alu_result = {31'b0, rs1_data_i < op_b};
      F3_XOR:  alu_result = rs1_data_i ^ op_b;
      F3_SR:   alu_result = alt_v ? rvga_word'($signed(rs1_data_i) >>> shamt)
                                  : (rs1_data_i >> shamt);
      F3_OR:   alu_result = rs1_data_i | op_b;
      F3_AND:  alu_result = rs1_data_i & op_b;
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    case (instr_i.r.funct3)
      F3_BEQ:  bru_n = (rs1_data_i == rs2_data_i);
      F3_BNE:  bru_n = (rs1_data_i != rs2_data_i);
      F3_BLT:  bru_n = ($signed(rs1_data_i) < $signed(rs2_data_i));
      F3_BGE:  bru_n = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      F3_BLTU: bru_n = (rs1_data_i < rs2_data_i);
      F3_BGEU: bru_n = (rs1_data_i >= rs2_data_i);
      default: bru_n = 1'b0; // not a branch encoding.
    endcase
  end

  always_comb begin
    if (is_branch) begin
      result_n = pc_i + b_imm;
    end else if (is_jal) begin
      result_n = pc_i + j_imm;
    end else if (is_op || is_op_imm) begin
      result_n = alu_result;
    end else begin
      result_n = '0;
    end
  end

  assign rd_w_v_n = (is_op || is_op_imm || is_jal) && (instr_i.r.rd != '0);

  // ****************************************
  // control word register
  // ****************************************

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cword_o.v          <= 1'b0;
      cword_o.pc         <= '0;
      cword_o.rd         <= '0;
      cword_o.rd_w_v     <= 1'b0;
      cword_o.br_v       <= 1'b0;
      cword_o.jmp_v      <= 1'b0;
      cword_o.bru_result <= 1'b0;
      cword_o.result     <= '0;
    end else begin
      cword_o.v          <= issue_v_i;
      cword_o.pc         <= pc_i;
      cword_o.rd         <= instr_i.r.rd;
      cword_o.rd_w_v     <= issue_v_i && rd_w_v_n;
      cword_o.br_v       <= issue_v_i && is_branch;
      cword_o.jmp_v      <= issue_v_i && is_jal;
      cword_o.bru_result <= is_branch && bru_n;
      cword_o.result     <= result_n;
    end
  end

endmodule : execute_stage

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage
  import rvga_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  wb_cword_if.wb   cword_i,
  output rvga_word br_tgt_o,
  output logic     br_v_o,
  output logic     btaken_o,
  output rvga_reg  rd_o,
  output rvga_word rd_data_o,
  output logic     rd_w_v_o,
  output logic     trace_v_o,
  output rvga_word trace_pc_o,
  output rvga_word trace_rd_data_o
);

  rvga_word rd_data;
  logic     trace_v_r;
  rvga_word trace_pc_r;
  rvga_word trace_rd_data_r;

  // ****************************************
  // rd select and branch outcome
  // ****************************************

  always_comb begin
    if (cword_i.jmp_v) begin
      rd_data = cword_i.pc + RVGA_PC_STEP; // link address.
    end else begin
      rd_data = cword_i.result;
    end
  end

  assign rd_data_o = rd_data;
  assign rd_o      = cword_i.rd;
  assign rd_w_v_o  = cword_i.rd_w_v;

  assign br_v_o   = cword_i.br_v | cword_i.jmp_v;
  assign btaken_o = cword_i.jmp_v | (cword_i.br_v & cword_i.bru_result);
  assign br_tgt_o = cword_i.result; // same field for branch and jal.

  // ****************************************
  // debug trace
  // ****************************************

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_v_r       <= 1'b0;
      trace_pc_r      <= '0;
      trace_rd_data_r <= '0;
    end else begin
      trace_v_r       <= cword_i.v;
      trace_pc_r      <= cword_i.pc;
      trace_rd_data_r <= rd_data;
    end
  end

  assign trace_v_o       = trace_v_r;
  assign trace_pc_o      = trace_pc_r;
  assign trace_rd_data_o = trace_rd_data_r;

endmodule : writeback_stage

/* verilog/rvga_backend.sv */
`timescale 1ns/1ps

module rvga_backend
  import rvga_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // issue side.
  input  logic     issue_v_i,
  input  rvga_word instr_i,
  input  rvga_word pc_i,

  // writeback side.
  output rvga_word br_tgt_o,
  output logic     br_v_o,
  output logic     btaken_o,
  output rvga_reg  rd_o,
  output rvga_word rd_data_o,
  output logic     rd_w_v_o,

  // debug trace, two cycles after issue.
  output logic     trace_v_o,
  output rvga_word trace_pc_o,
  output rvga_word trace_rd_data_o
);

  rvga_reg  rs1, rs2;
  rvga_word rs1_data, rs2_data;

  wb_cword_if cword ();

  // ****************************************
  // register file
  // ****************************************

  rvga_regfile regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .w_v_i      (rd_w_v_o),  // write at end of writeback cycle.
    .rd_i       (rd_o),
    .rd_data_i  (rd_data_o)
  );

  // ****************************************
  // pipeline stages
  // ****************************************

  execute_stage exe (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .issue_v_i  (issue_v_i),
    .instr_i    (instr_i),
    .pc_i       (pc_i),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .cword_o    (cword.exe)
  );

  writeback_stage wb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cword_i         (cword.wb),
    .br_tgt_o        (br_tgt_o),
    .br_v_o          (br_v_o),
    .btaken_o        (btaken_o),
    .rd_o            (rd_o),
    .rd_data_o       (rd_data_o),
    .rd_w_v_o        (rd_w_v_o),
    .trace_v_o       (trace_v_o),
    .trace_pc_o      (trace_pc_o),
    .trace_rd_data_o (trace_rd_data_o)
  );

endmodule : rvga_backend

/* tb/rvga_backend_assert.sv */
`timescale 1ns/1ps

module rvga_backend_assert
  import rvga_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    br_v_i,
  input logic    btaken_i,
  input logic    rd_w_v_i,
  input rvga_reg rd_i,
  input logic    trace_v_i
);

  taken_needs_branch: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) btaken_i |-> br_v_i
  ) else $error("btaken_o set without br_v_o");

  write_not_x0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rd_w_v_i |-> (rd_i != '0)
  ) else $error("rd_w_v_o set with rd_o of x0");

  // a retired write or branch shows up in the trace one cycle later.
  trace_follows: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (rd_w_v_i || br_v_i) |=> trace_v_i
  ) else $error("trace_v_o missing after writeback");

  quiet_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !(rd_w_v_i || br_v_i || btaken_i || trace_v_i)
  ) else $error("outputs active while reset is held");

endmodule : rvga_backend_assert

bind rvga_backend rvga_backend_assert chk (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .br_v_i    (br_v_o),
  .btaken_i  (btaken_o),
  .rd_w_v_i  (rd_w_v_o),
  .rd_i      (rd_o),
  .trace_v_i (trace_v_o)
);

/* tb/tb_rvga_backend.sv */
`timescale 1ns/1ps

module tb_rvga_backend
  import rvga_pkg::*;
();

  localparam int NUM_VECTORS = 38;
  localparam int FIELDS      = 9;
  localparam int MAX_CYCLES  = NUM_VECTORS * 5 + 16;

  localparam int COL_INSTR   = 0;
  localparam int COL_PC      = 1;
  localparam int COL_RD_W_V  = 2;
  localparam int COL_RD      = 3;
  localparam int COL_RD_DATA = 4;
  localparam int COL_BR_V    = 5;
  localparam int COL_BTAKEN  = 6;
  localparam int COL_BR_TGT  = 7;
  localparam int COL_CHAIN   = 8; // issue with no gap.

  logic     clk;
  logic     rst_n;
  logic     issue_v;
  rvga_word instr;
  rvga_word pc;
  rvga_word br_tgt;
  logic     br_v;
  logic     btaken;
  rvga_reg  rd;
  rvga_word rd_data;
  logic     rd_w_v;
  logic     trace_v;
  rvga_word trace_pc;
  rvga_word trace_rd_data;

  logic [31:0] vec_mem [0:NUM_VECTORS*FIELDS-1];
  int          vec_errs [0:NUM_VECTORS-1];
  int          errors;
  int          passed;
  int          failed;

  rvga_backend DUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .issue_v_i       (issue_v),
    .instr_i         (instr),
    .pc_i            (pc),
    .br_tgt_o        (br_tgt),
    .br_v_o          (br_v),
    .btaken_o        (btaken),
    .rd_o            (rd),
    .rd_data_o       (rd_data),
    .rd_w_v_o        (rd_w_v),
    .trace_v_o       (trace_v),
    .trace_pc_o      (trace_pc),
    .trace_rd_data_o (trace_rd_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] field(input int idx, input int col);
    return vec_mem[idx*FIELDS + col];
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_word(input int idx, input string name,
                              input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      if (idx >= 0) begin
        $display("[ERROR] vector %0d %s expected 0x%h got 0x%h", idx, name, exp, act);
        vec_errs[idx]++;
      end else begin
        $display("[ERROR] idle cycle %s expected 0x%h got 0x%h", name, exp, act);
      end
      errors++;
    end
  endtask

  task automatic check_idle();
    compare_word(-1, "rd_w_v_o", 32'd0, {31'b0, rd_w_v});
    compare_word(-1, "br_v_o", 32'd0, {31'b0, br_v});
    compare_word(-1, "btaken_o", 32'd0, {31'b0, btaken});
  endtask

  task automatic check_writeback(input int idx);
    compare_word(idx, "rd_w_v_o", field(idx, COL_RD_W_V), {31'b0, rd_w_v});
    if (field(idx, COL_RD_W_V) != 0) begin
      compare_word(idx, "rd_o", field(idx, COL_RD), {27'b0, rd});
    end
    compare_word(idx, "rd_data_o", field(idx, COL_RD_DATA), rd_data);
    compare_word(idx, "br_v_o", field(idx, COL_BR_V), {31'b0, br_v});
    compare_word(idx, "btaken_o", field(idx, COL_BTAKEN), {31'b0, btaken});
    compare_word(idx, "br_tgt_o", field(idx, COL_BR_TGT), br_tgt);
  endtask

  // last check of a vector prints its result line.
  task automatic check_trace(input int idx);
    compare_word(idx, "trace_v_o", 32'd1, {31'b0, trace_v});
    compare_word(idx, "trace_pc_o", field(idx, COL_PC), trace_pc);
    compare_word(idx, "trace_rd_data_o", field(idx, COL_RD_DATA), trace_rd_data);
    if (vec_errs[idx] == 0) begin
      passed++;
      $display("vector %0d pc 0x%h instr 0x%h ok", idx, field(idx, COL_PC),
               field(idx, COL_INSTR));
    end else begin
      failed++;
      $display("vector %0d pc 0x%h instr 0x%h: %0d mismatches", idx, field(idx, COL_PC),
               field(idx, COL_INSTR), vec_errs[idx]);
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  initial begin
    logic [31:0] seed;
    int          cycle;
    int          next_idx;
    int          wb_idx;
    int          trace_idx;
    int          gap;
    int          idle_errs;

    clk     = 1'b0;
    rst_n   = 1'b0;
    issue_v = 1'b0;
    instr   = '0;
    pc      = '0;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    for (int k = 0; k < NUM_VECTORS; k++) begin
      vec_errs[k] = 0;
    end
    $readmemh("tb/rvga_vectors.txt", vec_mem);

    cycle = 0;
    while (cycle < 2) begin
      @(negedge clk);
      cycle++;
    end
    rst_n = 1'b1;

    idle_errs = errors;
    cycle     = 0;
    while (cycle < 3) begin
      @(negedge clk);
      check_idle();
      compare_word(-1, "trace_v_o", 32'd0, {31'b0, trace_v});
      cycle++;
    end
    if (errors == idle_errs) begin
      passed++;
      $display("reset idle ok");
    end else begin
      failed++;
      $display("reset idle: outputs active with no issue");
    end

    seed      = 32'd55341;
    next_idx  = 0;
    wb_idx    = -1;
    trace_idx = -1;
    gap       = 0;
    cycle     = 0;
    while ((next_idx < NUM_VECTORS || wb_idx >= 0 || trace_idx >= 0) &&
           cycle < MAX_CYCLES) begin
      @(negedge clk);
      cycle++;
      if (wb_idx >= 0) begin
        check_writeback(wb_idx);
      end else begin
        check_idle();
      end
      if (trace_idx >= 0) begin
        check_trace(trace_idx);
      end else begin
        compare_word(-1, "trace_v_o", 32'd0, {31'b0, trace_v});
      end
      trace_idx = wb_idx;
      wb_idx    = -1;
      if (next_idx < NUM_VECTORS && gap == 0) begin
        issue_v = 1'b1;
        instr   = field(next_idx, COL_INSTR);
        pc      = field(next_idx, COL_PC);
        wb_idx  = next_idx;
        next_idx++;
        seed = next_random(seed);
        gap  = int'(seed % 32'd4);
        if (next_idx < NUM_VECTORS && field(next_idx, COL_CHAIN) != 0) begin
          gap = 0; // dependent pair hits the bypass.
        end
      end else begin
        issue_v = 1'b0; // last instr and pc stay on the bus.
        if (gap > 0) begin
          gap--;
        end
      end
    end

    $display("checks: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (next_idx < NUM_VECTORS || wb_idx >= 0 || trace_idx >= 0) begin
      $display("timeout: vectors still in flight after %0d cycles", cycle);
      $display("test failed");
    end else if (errors == 0 && failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_rvga_backend

/* tb/rvga_vectors.txt */
// instr pc rd_w_v rd rd_data br_v btaken br_tgt chain, all hex
// chain 1 issues the vector in the cycle right after the one before it
00500093 00000100 1 01 00000005 0 0 00000005 0 // addi x1, x0, 5
ffd00113 00000104 1 02 fffffffd 0 0 fffffffd 0 // addi x2, x0, -3
7ff00193 00000108 1 03 000007ff 0 0 000007ff 0 // addi x3, x0, 2047
80000213 0000010c 1 04 fffff800 0 0 fffff800 0 // addi x4, x0, -2048
002082b3 00000110 1 05 00000002 0 0 00000002 0 // add x5, x1, x2
40208333 00000114 1 06 00000008 0 0 00000008 0 // sub x6, x1, x2
003173b3 00000118 1 07 000007fd 0 0 000007fd 0 // and x7, x2, x3
0040e433 0000011c 1 08 fffff805 0 0 fffff805 0 // or x8, x1, x4
003144b3 00000120 1 09 fffff802 0 0 fffff802 0 // xor x9, x2, x3
00112533 00000124 1 0a 00000001 0 0 00000001 0 // slt x10, x2, x1
001135b3 00000128 1 0b 00000000 0 0 00000000 0 // sltu x11, x2, x1
00109633 0000012c 1 0c 000000a0 0 0 000000a0 0 // sll x12, x1, x1
001156b3 00000130 1 0d 07ffffff 0 0 07ffffff 0 // srl x13, x2, x1
40115733 00000134 1 0e ffffffff 0 0 ffffffff 0 // sra x14, x2, x1
0f017793 00000138 1 0f 000000f0 0 0 000000f0 0 // andi x15, x2, 0xf0
ff00e813 0000013c 1 10 fffffff5 0 0 fffffff5 0 // ori x16, x1, -16
fff1c893 00000140 1 11 fffff800 0 0 fffff800 0 // xori x17, x3, -1
fff22913 00000144 1 12 00000001 0 0 00000001 0 // slti x18, x4, -1
fff0b993 00000148 1 13 00000001 0 0 00000001 0 // sltiu x19, x1, -1
00419a13 0000014c 1 14 00007ff0 0 0 00007ff0 0 // slli x20, x3, 4
00825a93 00000150 1 15 00fffff8 0 0 00fffff8 0 // srli x21, x4, 8
40825b13 00000154 1 16 fffffff8 0 0 fffffff8 0 // srai x22, x4, 8
12300b93 00000158 1 17 00000123 0 0 00000123 0 // addi x23, x0, 0x123
010b8c13 0000015c 1 18 00000133 0 0 00000133 1 // addi x24, x23, 16
017c0cb3 00000160 1 19 00000256 0 0 00000256 1 // add x25, x24, x23
401c8d33 00000164 1 1a 00000251 0 0 00000251 1 // sub x26, x25, x1
00108033 00000168 0 00 0000000a 0 0 0000000a 0 // add x0, x1, x1
00100db3 0000016c 1 1b 00000005 0 0 00000005 1 // add x27, x0, x1
00108863 00000170 0 00 00000180 1 1 00000180 0 // beq x1, x1, +16
fe209ce3 00000174 0 00 0000016c 1 1 0000016c 0 // bne x1, x2, -8
00114463 00000178 0 00 00000180 1 1 00000180 0 // blt x2, x1, +8
00115463 0000017c 0 00 00000184 1 0 00000184 0 // bge x2, x1, +8
00116463 00000180 0 00 00000188 1 0 00000188 0 // bltu x2, x1, +8
001170e3 00000184 0 00 00000984 1 1 00000984 0 // bgeu x2, x1, +2048
020000ef 00000188 1 01 0000018c 1 1 000001a8 0 // jal x1, +32
ff1ff06f 0000018c 0 00 00000190 1 1 0000017c 0 // jal x0, -16
123452b7 00000190 0 00 00000000 0 0 00000000 0 // lui x5, not supported
00028e33 00000194 1 1c 00000002 0 0 00000002 1 // add x28, x5, x0

/* compile.f */
verilog/rvga_pkg.sv
verilog/wb_cword_if.sv
verilog/rvga_regfile.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rvga_backend.sv
tb/rvga_backend_assert.sv
tb/tb_rvga_backend.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_rvga_backend -f compile.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
